// File: include/modexp_defs.svh
/* word width is fixed at 32 bits and the word count must be 2 or more
   operands wider than the word count are not supported */
`ifndef MODEXP_DEFS_SVH
`define MODEXP_DEFS_SVH

`define MODEXP_WORD_WIDTH 32 // bits per operand word
`define MODEXP_WORD_COUNT 4  // words per operand (128 bits)

// one extra bit so an index can reach the word count itself
`define MODEXP_INDEX_WIDTH ($clog2(`MODEXP_WORD_COUNT) + 1)

// addresses every exponent bit
`define MODEXP_BIT_INDEX_WIDTH ($clog2(`MODEXP_WORD_COUNT * `MODEXP_WORD_WIDTH))

`endif

// File: source/modexp_pkg.sv
/* types shared by the exponentiator blocks; word_t follows MODEXP_WORD_WIDTH */
`include "modexp_defs.svh"

package modexp_pkg;

	typedef logic [`MODEXP_WORD_WIDTH-1:0] word_t;

	// operand an input word belongs to
	typedef enum logic [2:0] {
		kind_modulus,
		kind_exponent,
		kind_base,
		kind_r_mod,
		kind_r2,
		kind_n0prime
	} operand_kind_e;

	// stored vector read or written by a product
	typedef enum logic [2:0] {
		sel_c_bar,
		sel_m_bar,
		sel_base,
		sel_r2,
		sel_one // constant 1, generated in the store
	} operand_sel_e;

	typedef enum logic [2:0] {
		ps_idle, ps_mul_row, ps_fold_top, ps_find_m,
		ps_reduce_row, ps_shift_top, ps_shift_carry, ps_write_back
	} product_state_e;

	typedef enum logic [2:0] {
		es_idle, es_to_mont, es_init_c, es_square,
		es_multiply, es_from_mont, es_stream_out
	} exp_state_e;

endpackage

// File: source/operand_store.sv
/* operand words of one kind arrive back to back, least significant first;
   words past the word count are dropped. Only c_bar and m_bar take product writes */
`timescale 1ns/1ns
`include "modexp_defs.svh"

module operand_store (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  modexp_pkg::operand_kind_e in_kind,
	input  modexp_pkg::word_t in_data,
	input  logic accept,
	input  modexp_pkg::operand_sel_e rd_a_sel,
	input  modexp_pkg::operand_sel_e rd_b_sel,
	input  logic [`MODEXP_INDEX_WIDTH-1:0] rd_a_idx,
	input  logic [`MODEXP_INDEX_WIDTH-1:0] rd_b_idx,
	input  logic [`MODEXP_INDEX_WIDTH-1:0] rd_n_idx,
	input  logic [`MODEXP_INDEX_WIDTH-1:0] out_idx,
	input  logic [`MODEXP_INDEX_WIDTH-1:0] wr_idx,
	input  logic [`MODEXP_BIT_INDEX_WIDTH-1:0] bit_idx,
	input  logic wr_en,
	input  modexp_pkg::operand_sel_e wr_sel,
	input  modexp_pkg::word_t wr_data,
	input  logic copy_r,
	output logic in_ready,
	output modexp_pkg::word_t rd_a_data,
	output modexp_pkg::word_t rd_b_data,
	output modexp_pkg::word_t rd_n_data,
	output modexp_pkg::word_t n0prime,
	output modexp_pkg::word_t out_data,
	output logic e_bit
);
	import modexp_pkg::*;

	localparam int W = `MODEXP_WORD_WIDTH;
	localparam int WC = `MODEXP_WORD_COUNT;
	localparam int IW = `MODEXP_INDEX_WIDTH;
	localparam int AW = IW - 1; // bits that address a stored word

	word_t modulus [WC];
	word_t exponent [WC];
	word_t base [WC];
	word_t r_mod [WC];
	word_t r2 [WC];
	word_t c_bar [WC];
	word_t m_bar [WC];
	operand_kind_e prev_kind;
	logic [IW-1:0] load_idx;
	logic [IW-1:0] put_idx;
	logic take;
	logic [WC*W-1:0] exp_flat;

	function automatic word_t pick(operand_sel_e sel, logic [IW-1:0] idx);
		word_t w;
		case (sel)
			sel_c_bar: w = c_bar[idx[AW-1:0]];
			sel_m_bar: w = m_bar[idx[AW-1:0]];
			sel_base:  w = base[idx[AW-1:0]];
			sel_r2:    w = r2[idx[AW-1:0]];
			default:   w = (idx == '0) ? word_t'(1) : '0; // the constant one
		endcase
		return w;
	endfunction

	assign in_ready = accept;
	assign take = in_valid && accept;
	assign put_idx = (in_kind == prev_kind) ? load_idx : '0; // new kind restarts at word 0

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			prev_kind <= kind_modulus;
			load_idx <= '0;
		end else if (take) begin
			prev_kind <= in_kind;
			if (put_idx < IW'(WC))
				load_idx <= put_idx + 1'b1;
			else
				load_idx <= put_idx; // saturate at the word count
		end
	end

	always_ff @(posedge clk) begin
		if (take && put_idx < IW'(WC)) begin
			case (in_kind)
				kind_modulus:  modulus[put_idx[AW-1:0]] <= in_data;
				kind_exponent: exponent[put_idx[AW-1:0]] <= in_data;
				kind_base:     base[put_idx[AW-1:0]] <= in_data;
				kind_r_mod:    r_mod[put_idx[AW-1:0]] <= in_data;
				kind_r2:       r2[put_idx[AW-1:0]] <= in_data;
				default:       n0prime <= in_data;
			endcase
		end
		if (copy_r) begin
			for (int k = 0; k < WC; k++)
				c_bar[k] <= r_mod[k]; // whole vector in one cycle
		end else if (wr_en) begin
			case (wr_sel)
				sel_c_bar: c_bar[wr_idx[AW-1:0]] <= wr_data;
				sel_m_bar: m_bar[wr_idx[AW-1:0]] <= wr_data;
				default: ;
			endcase
		end
	end

	always_comb begin
		for (int k = 0; k < WC; k++)
			exp_flat[k*W +: W] = exponent[k];
	end

	assign rd_a_data = pick(rd_a_sel, rd_a_idx);
	assign rd_b_data = pick(rd_b_sel, rd_b_idx);
	assign rd_n_data = modulus[rd_n_idx[AW-1:0]];
	assign out_data = c_bar[out_idx[AW-1:0]];
	assign e_bit = exp_flat[bit_idx];

	// sequencer closes the input port before the engine may write back
	a_no_write_during_load: assert property (@(posedge clk) disable iff (reset)
		!(wr_en && take));

endmodule

// File: source/mont_product.sv
/* CIOS Montgomery product; operands must be below the modulus, and the
   result is reduced below it. prod_start is only honoured while idle */
`timescale 1ns/1ns
`include "modexp_defs.svh"

module mont_product (
	input  logic clk,
	input  logic reset,
	input  logic prod_start,
	input  modexp_pkg::operand_sel_e prod_a,
	input  modexp_pkg::operand_sel_e prod_b,
	input  modexp_pkg::operand_sel_e prod_dest,
	input  modexp_pkg::word_t rd_a_data,
	input  modexp_pkg::word_t rd_b_data,
	input  modexp_pkg::word_t rd_n_data,
	input  modexp_pkg::word_t n0prime,
	output modexp_pkg::operand_sel_e rd_a_sel,
	output modexp_pkg::operand_sel_e rd_b_sel,
	output logic [`MODEXP_INDEX_WIDTH-1:0] rd_a_idx,
	output logic [`MODEXP_INDEX_WIDTH-1:0] rd_b_idx,
	output logic [`MODEXP_INDEX_WIDTH-1:0] rd_n_idx,
	output logic wr_en,
	output modexp_pkg::operand_sel_e wr_sel,
	output logic [`MODEXP_INDEX_WIDTH-1:0] wr_idx,
	output modexp_pkg::word_t wr_data,
	output logic prod_done
);
	import modexp_pkg::*;

	localparam int W = `MODEXP_WORD_WIDTH;
	localparam int WC = `MODEXP_WORD_COUNT;
	localparam int IW = `MODEXP_INDEX_WIDTH;

	product_state_e state;
	logic phase; // 0 issue, 1 capture
	logic wb_pass; // write_back sweep 0 compares, sweep 1 writes
	logic [IW-1:0] i_idx;
	logic [IW-1:0] j_idx;
	logic [IW-1:0] j_prev;
	logic last_j;
	operand_sel_e a_sel;
	operand_sel_e b_sel;
	operand_sel_e dest_sel;
	word_t v [WC+2]; // accumulator, two words above the operand
	word_t carry;
	word_t m_word;
	word_t mac_x;
	word_t mac_y;
	word_t mac_z;
	word_t mac_cin;
	logic [2*W-1:0] mac_q; // registered multiply-add
	logic borrow;
	logic sub_en;
	logic [W:0] diff;

	assign j_prev = j_idx - 1'b1;
	assign last_j = (j_idx == IW'(WC - 1));

	// operands of the multiply-add for the issue cycle
	always_comb begin
		mac_x = '0;
		mac_y = '0;
		mac_z = '0;
		mac_cin = '0;
		case (state)
			ps_mul_row: begin
				mac_x = rd_a_data;
				mac_y = rd_b_data;
				mac_z = v[j_idx];
				mac_cin = (j_idx == '0) ? '0 : carry;
			end
			ps_fold_top, ps_shift_top: begin
				mac_z = v[WC];
				mac_cin = carry;
			end
			ps_find_m: begin
				mac_x = v[0];
				mac_y = n0prime; // m is v[0]*n0prime mod 2^32
			end
			ps_reduce_row: begin
				mac_x = m_word;
				mac_y = rd_n_data;
				mac_z = v[j_idx];
				mac_cin = (j_idx == '0) ? '0 : carry;
			end
			ps_shift_carry: begin
				mac_z = v[WC+1];
				mac_cin = carry;
			end
			default: ;
		endcase
	end

	assign diff = {1'b0, v[j_idx]} - {1'b0, rd_n_data} - {{W{1'b0}}, borrow};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ps_idle;
			phase <= 1'b0;
			wb_pass <= 1'b0;
			i_idx <= '0;
			j_idx <= '0;
			prod_done <= 1'b0;
			a_sel <= sel_c_bar;
			b_sel <= sel_c_bar;
			dest_sel <= sel_c_bar;
		end else begin
			prod_done <= 1'b0;
			case (state)
				ps_idle: if (prod_start) begin
					a_sel <= prod_a;
					b_sel <= prod_b;
					dest_sel <= prod_dest;
					i_idx <= '0;
					j_idx <= '0;
					phase <= 1'b0;
					state <= ps_mul_row;
				end
				ps_write_back: begin
					j_idx <= last_j ? '0 : j_idx + 1'b1;
					if (last_j) begin
						wb_pass <= ~wb_pass;
						if (wb_pass) begin
							prod_done <= 1'b1; // one cycle after the last write
							state <= ps_idle;
						end
					end
				end
				default: begin
					phase <= ~phase;
					if (phase) begin
						case (state)
							ps_mul_row, ps_reduce_row: begin
								j_idx <= last_j ? '0 : j_idx + 1'b1;
								if (last_j)
									state <= (state == ps_mul_row) ? ps_fold_top : ps_shift_top;
							end
							ps_fold_top: state <= ps_find_m;
							ps_find_m: state <= ps_reduce_row;
							ps_shift_top: state <= ps_shift_carry;
							default: begin // shift_carry closes one outer word
								i_idx <= (i_idx == IW'(WC - 1)) ? '0 : i_idx + 1'b1;
								state <= (i_idx == IW'(WC - 1)) ? ps_write_back : ps_mul_row;
							end
						endcase
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		mac_q <= {{W{1'b0}}, mac_x} * {{W{1'b0}}, mac_y} + {{W{1'b0}}, mac_z}
			+ {{W{1'b0}}, mac_cin};
		if (state == ps_idle && prod_start) begin
			for (int k = 0; k < WC + 2; k++)
				v[k] <= '0;
			carry <= '0;
			borrow <= 1'b0;
		end else if (phase) begin
			case (state)
				ps_mul_row: begin
					v[j_idx] <= mac_q[W-1:0];
					carry <= mac_q[2*W-1:W];
				end
				ps_fold_top: begin
					v[WC] <= mac_q[W-1:0];
					v[WC+1] <= mac_q[2*W-1:W];
				end
				ps_find_m: m_word <= mac_q[W-1:0];
				ps_reduce_row: begin
					if (j_idx != '0)
						v[j_prev] <= mac_q[W-1:0]; // shifted down one word
					carry <= mac_q[2*W-1:W];
				end
				ps_shift_top: begin
					v[WC-1] <= mac_q[W-1:0];
					carry <= mac_q[2*W-1:W];
				end
				ps_shift_carry: v[WC] <= mac_q[W-1:0];
				default: ;
			endcase
		end
		if (state == ps_write_back) begin
			borrow <= last_j ? 1'b0 : diff[W];
			if (!wb_pass && last_j)
				sub_en <= (v[WC] != '0) || !diff[W]; // v >= n
		end
	end

	assign rd_a_sel = a_sel;
	assign rd_b_sel = b_sel;
	assign rd_a_idx = i_idx;
	assign rd_b_idx = j_idx;
	assign rd_n_idx = j_idx;
	assign wr_en = (state == ps_write_back) && wb_pass;
	assign wr_sel = dest_sel;
	assign wr_idx = j_idx;
	assign wr_data = sub_en ? diff[W-1:0] : v[j_idx];

	a_top_word_bound: assert property (@(posedge clk) disable iff (reset)
		(state == ps_shift_carry && phase) |=> (v[WC] <= word_t'(1)));

	a_start_when_idle: assert property (@(posedge clk) disable iff (reset)
		prod_start |-> (state == ps_idle));

endmodule

// File: source/exp_sequencer.sv
/* left to right square and multiply over every exponent bit, leading zeros
   included; the result goes out least significant word first */
`timescale 1ns/1ns
`include "modexp_defs.svh"

module exp_sequencer (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic e_bit,
	input  logic prod_done,
	input  logic out_ready,
	input  modexp_pkg::word_t in_data_word,
	output logic busy,
	output logic accept,
	output logic prod_start,
	output modexp_pkg::operand_sel_e prod_a,
	output modexp_pkg::operand_sel_e prod_b,
	output modexp_pkg::operand_sel_e prod_dest,
	output logic copy_r,
	output logic [`MODEXP_BIT_INDEX_WIDTH-1:0] bit_idx,
	output logic [`MODEXP_INDEX_WIDTH-1:0] out_idx,
	output logic out_valid,
	output logic out_last,
	output modexp_pkg::word_t out_data
);
	import modexp_pkg::*;

	localparam int WC = `MODEXP_WORD_COUNT;
	localparam int IW = `MODEXP_INDEX_WIDTH;
	localparam int BW = `MODEXP_BIT_INDEX_WIDTH;
	localparam logic [BW-1:0] TOP_BIT = BW'(WC * `MODEXP_WORD_WIDTH - 1);

	exp_state_e state;

	assign busy = (state != es_idle);
	assign accept = (state == es_idle);
	assign copy_r = (state == es_init_c); // square is issued in the same cycle

	always_comb begin
		prod_a = sel_c_bar;
		prod_b = sel_c_bar;
		prod_dest = sel_c_bar;
		case (state)
			es_to_mont: begin
				prod_a = sel_base;
				prod_b = sel_r2;
				prod_dest = sel_m_bar;
			end
			es_multiply: prod_b = sel_m_bar;
			es_from_mont: prod_b = sel_one;
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= es_idle;
			prod_start <= 1'b0;
			bit_idx <= '0;
			out_idx <= '0;
			out_valid <= 1'b0;
			out_last <= 1'b0;
		end else begin
			prod_start <= 1'b0;
			case (state)
				es_idle: if (start) begin
					bit_idx <= TOP_BIT;
					prod_start <= 1'b1;
					state <= es_to_mont;
				end
				es_to_mont: if (prod_done) begin
					prod_start <= 1'b1;
					state <= es_init_c;
				end
				es_init_c: state <= es_square;
				es_square: if (prod_done) begin
					prod_start <= 1'b1;
					if (e_bit)
						state <= es_multiply;
					else if (bit_idx == '0)
						state <= es_from_mont;
					else
						bit_idx <= bit_idx - 1'b1; // square again
				end
				es_multiply: if (prod_done) begin
					prod_start <= 1'b1;
					if (bit_idx == '0) begin
						state <= es_from_mont;
					end else begin
						bit_idx <= bit_idx - 1'b1;
						state <= es_square;
					end
				end
				es_from_mont: if (prod_done) begin
					out_idx <= '0;
					state <= es_stream_out;
				end
				default: begin
					if (!out_valid) begin
						out_valid <= 1'b1;
						out_last <= (out_idx == IW'(WC - 1));
						out_idx <= out_idx + 1'b1;
					end else if (out_ready) begin
						out_valid <= 1'b0;
						out_last <= 1'b0;
						if (out_last)
							state <= es_idle;
					end
				end
			endcase
		end
	end

	// held while the host stalls
	always_ff @(posedge clk) begin
		if (state == es_stream_out && !out_valid)
			out_data <= in_data_word;
	end

endmodule

// File: source/modexp_top.sv
/* host loads all six operands before start; in_ready stays low while busy */
`timescale 1ns/1ns
`include "modexp_defs.svh"

module modexp_top (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  modexp_pkg::operand_kind_e in_kind,
	input  modexp_pkg::word_t in_data,
	input  logic start,
	input  logic out_ready,
	output logic in_ready,
	output logic busy,
	output logic out_valid,
	output modexp_pkg::word_t out_data,
	output logic out_last
);
	import modexp_pkg::*;

	operand_sel_e rd_a_sel;
	operand_sel_e rd_b_sel;
	operand_sel_e wr_sel;
	operand_sel_e prod_a;
	operand_sel_e prod_b;
	operand_sel_e prod_dest;
	logic [`MODEXP_INDEX_WIDTH-1:0] rd_a_idx;
	logic [`MODEXP_INDEX_WIDTH-1:0] rd_b_idx;
	logic [`MODEXP_INDEX_WIDTH-1:0] rd_n_idx;
	logic [`MODEXP_INDEX_WIDTH-1:0] wr_idx;
	logic [`MODEXP_INDEX_WIDTH-1:0] out_idx;
	logic [`MODEXP_BIT_INDEX_WIDTH-1:0] bit_idx;
	word_t rd_a_data;
	word_t rd_b_data;
	word_t rd_n_data;
	word_t n0prime;
	word_t wr_data;
	word_t c_word; // c_bar word for streaming
	logic wr_en;
	logic copy_r;
	logic accept;
	logic e_bit;
	logic prod_start;
	logic prod_done;

	operand_store u_store (
		.clk, .reset, .in_valid, .in_kind, .in_data, .accept,
		.rd_a_sel, .rd_b_sel, .rd_a_idx, .rd_b_idx, .rd_n_idx,
		.out_idx, .wr_idx, .bit_idx, .wr_en, .wr_sel, .wr_data, .copy_r,
		.in_ready, .rd_a_data, .rd_b_data, .rd_n_data, .n0prime,
		.out_data(c_word), .e_bit
	);

	mont_product u_product (
		.clk, .reset, .prod_start, .prod_a, .prod_b, .prod_dest,
		.rd_a_data, .rd_b_data, .rd_n_data, .n0prime,
		.rd_a_sel, .rd_b_sel, .rd_a_idx, .rd_b_idx, .rd_n_idx,
		.wr_en, .wr_sel, .wr_idx, .wr_data, .prod_done
	);

	exp_sequencer u_sequencer (
		.clk, .reset, .start, .e_bit, .prod_done, .out_ready,
		.in_data_word(c_word), .busy, .accept, .prod_start,
		.prod_a, .prod_b, .prod_dest, .copy_r, .bit_idx, .out_idx,
		.out_valid, .out_last, .out_data
	);

endmodule

// File: bench/modexp_tb.sv
/* the 128-bit reference model needs a word count of 4
   moduli are odd with the top bit set and bases are reduced below them */
`timescale 1ns/1ns
`include "modexp_defs.svh"

module modexp_tb;
	import modexp_pkg::*;

	localparam int WC = `MODEXP_WORD_COUNT;
	localparam int RUN_LIMIT = 60000; // cycles from start to the first result word
	localparam int WORD_LIMIT = 400;
	localparam int LOAD_LIMIT = 200;

	logic clk;
	logic reset;
	logic in_valid;
	operand_kind_e in_kind;
	word_t in_data;
	logic start;
	logic out_ready;
	logic in_ready;
	logic busy;
	logic out_valid;
	word_t out_data;
	logic out_last;

	int seed;
	int tests;
	int errors;
	logic stalled;
	logic running; // from the start edge to the last result handshake
	logic [127:0] n_val;
	logic [127:0] e_val;
	logic [127:0] b_val;
	logic [127:0] got;
	logic [3:0] last_flags;

	modexp_top u_dut (
		.clk, .reset, .in_valid, .in_kind, .in_data, .start, .out_ready,
		.in_ready, .busy, .out_valid, .out_data, .out_last
	);

	always #20 clk = ~clk;

	function automatic logic [127:0] mod_mul(input logic [127:0] a, input logic [127:0] b,
			input logic [127:0] n);
		logic [255:0] p;
		p = {128'b0, a} * {128'b0, b};
		p = p % {128'b0, n};
		return p[127:0];
	endfunction

	function automatic logic [127:0] mod_pow(input logic [127:0] b, input logic [127:0] e,
			input logic [127:0] n);
		logic [127:0] acc;
		acc = 128'd1;
		for (int k = 127; k >= 0; k--) begin
			acc = mod_mul(acc, acc, n);
			if (e[k])
				acc = mod_mul(acc, b, n);
		end
		return acc;
	endfunction

	// each Newton step doubles the number of correct low bits
	function automatic word_t neg_inverse(input word_t n0);
		word_t x;
		x = n0;
		for (int k = 0; k < 5; k++)
			x = x * (32'd2 - n0 * x);
		return 32'd0 - x;
	endfunction

	task automatic random_wide(output logic [127:0] value);
		for (int k = 0; k < 4; k++)
			value[k*32 +: 32] = $random(seed);
	endtask

	task automatic pick_operands();
		random_wide(n_val);
		n_val[127] = 1'b1;
		n_val[0] = 1'b1; // Montgomery needs an odd modulus
		random_wide(b_val);
		b_val = b_val % n_val;
		random_wide(e_val);
	endtask

	task automatic check_result(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		tests++;
		assert (actual === expected) begin
			$display("pass %s expected %h actual %h", name, expected, actual);
		end else begin
			errors++;
			$display("Fail %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic send_word(input operand_kind_e kind, input word_t data);
		int waited;
		waited = 0;
		@(posedge clk);
		in_valid <= 1'b1;
		in_kind <= kind;
		in_data <= data;
		@(negedge clk);
		while (!in_ready && waited < LOAD_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!in_ready) begin
			$display("timeout: input port stayed closed for %0d cycles", LOAD_LIMIT);
			stalled = 1'b1;
		end
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic send_operand(input operand_kind_e kind, input logic [127:0] value);
		for (int k = 0; k < WC && !stalled; k++)
			send_word(kind, value[k*32 +: 32]);
	endtask

	// loads, starts and collects one exponentiation
	task automatic run_exp(input logic [127:0] n, input logic [127:0] e,
			input logic [127:0] b, input logic bp, input logic poke,
			output logic [127:0] result);
		logic [255:0] r_wide;
		int waited;
		int count;
		result = '0;
		r_wide = (256'd1 << 128) % {128'b0, n};
		send_operand(kind_modulus, n);
		send_operand(kind_exponent, e);
		send_operand(kind_base, b);
		send_operand(kind_r_mod, r_wide[127:0]);
		send_operand(kind_r2, mod_mul(r_wide[127:0], r_wide[127:0], n));
		if (!stalled)
			send_word(kind_n0prime, neg_inverse(n[31:0]));
		if (stalled)
			return;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		running <= 1'b1;
		if (poke) begin
			in_valid <= 1'b1; // must be refused while busy
			in_kind <= kind_modulus;
			in_data <= 32'hdead_beef;
			repeat (3) @(posedge clk);
			start <= 1'b1; // second start while busy
			@(posedge clk);
			start <= 1'b0;
		end
		waited = 0;
		@(negedge clk);
		while (!out_valid && waited < RUN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!out_valid) begin
			$display("timeout: no result word within %0d cycles of start", RUN_LIMIT);
			stalled = 1'b1;
			return;
		end
		count = 0;
		waited = 0;
		while (count < WC && waited < WORD_LIMIT) begin
			@(posedge clk);
			in_valid <= 1'b0;
			out_ready <= bp ? 1'($random(seed)) : 1'b1;
			@(negedge clk);
			if (out_valid && out_ready) begin
				result[count*32 +: 32] = out_data;
				last_flags[count] = out_last;
				count++;
			end
			waited++;
		end
		@(posedge clk);
		out_ready <= 1'b0;
		running <= 1'b0;
		if (count < WC) begin
			$display("timeout: only %0d of %0d result words arrived", count, WC);
			stalled = 1'b1;
		end
	endtask

	hold_under_stall: assert property (@(posedge clk) disable iff (reset)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last)))
	else begin
		errors++;
		$display("output word or last flag changed while the host stalled");
	end

	busy_tracks_run: assert property (@(posedge clk) disable iff (reset)
		(busy === running) && (in_ready === !running))
	else begin
		errors++;
		$display("busy or in_ready did not follow the run from start to the last result word");
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_kind = kind_modulus;
		in_data = '0;
		start = 1'b0;
		out_ready = 1'b0;
		seed = 32'h4d57_9aba;
		tests = 0;
		errors = 0;
		stalled = 1'b0;
		running = 1'b0;
		last_flags = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_result("reset_state", 128'b100, {125'b0, in_ready, out_valid, busy});

		for (int t = 0; t < 4 && !stalled; t++) begin
			pick_operands();
			run_exp(n_val, e_val, b_val, 1'b0, 1'b0, got);
			if (!stalled)
				check_result($sformatf("random_%0d", t), mod_pow(b_val, e_val, n_val), got);
		end
		if (!stalled) begin
			pick_operands();
			run_exp(n_val, 128'd0, b_val, 1'b0, 1'b0, got);
		end
		if (!stalled)
			check_result("exp_zero", 128'd1, got);
		if (!stalled)
			run_exp(n_val, 128'd1, b_val, 1'b0, 1'b0, got);
		if (!stalled)
			check_result("exp_one", b_val, got);
		if (!stalled) begin
			pick_operands();
			last_flags = '0;
			run_exp(n_val, e_val, b_val, 1'b1, 1'b0, got);
		end
		if (!stalled) begin
			check_result("back_pressure", mod_pow(b_val, e_val, n_val), got);
			check_result("framing", 128'b1000, {124'b0, last_flags});
			pick_operands();
			run_exp(n_val, e_val, b_val, 1'b0, 1'b1, got);
		end
		if (!stalled)
			check_result("busy_restart", mod_pow(b_val, e_val, n_val), got);

		$display("tests run %0d, errors %0d", tests, errors);
		if (errors == 0 && !stalled)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+include
source/modexp_pkg.sv
source/operand_store.sv
source/mont_product.sv
source/exp_sequencer.sv
source/modexp_top.sv
bench/modexp_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run the testbench, then scan the log for the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module modexp_tb -o modexp_sim -f vlog.f \
	|| { echo "build error"; exit 1; }
./obj_dir/modexp_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Testbench failed" sim.log && { echo "result: FAIL"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "result: no verdict in log"; exit 1; }
echo "result: PASS"
